/* logic/rbus_pkg.sv */
package rbus_pkg;

    // ring geometry.
    localparam int ring_addr_w = 32;
    localparam int locl_addr_w = 8;
    localparam int data_w      = 32;
    localparam int n_nodes     = 3;

    // node k owns win_base + k*win_size up to the next window.
    localparam logic [ring_addr_w-1:0] win_base = 32'h0000_1000;
    localparam logic [ring_addr_w-1:0] win_size = 32'h0000_0100;

    // request beat on the ring.
    typedef struct packed {
        logic [ring_addr_w-1:0] addr;
        logic                   wr_strb;
        logic [data_w-1:0]      wr_data;
        logic                   rd_strb;
    } rbus_req_t;

    // request beat into a register block.
    typedef struct packed {
        logic [locl_addr_w-1:0] addr;
        logic                   wr_strb;
        logic [data_w-1:0]      wr_data;
        logic                   rd_strb;
    } locl_req_t;

    // response beat, ack or err_ack pulses for one cycle.
    typedef struct packed {
        logic [data_w-1:0] rd_data;
        logic              ack;
        logic              err_ack;
    } rbus_rsp_t;

    typedef struct packed {
        logic [data_w-1:0] rd_data;
        logic              err;
    } host_rsp_t;

    typedef enum logic [1:0] {
        idle,
        wait_rsp,
        done
    } master_state_e;

endpackage

/* logic/rbus_ring_node.sv */
`timescale 1ns/100ps

module rbus_ring_node #(
    parameter logic [rbus_pkg::ring_addr_w-1:0] win_start = rbus_pkg::win_base,
    parameter logic [rbus_pkg::ring_addr_w-1:0] win_end   = rbus_pkg::win_base + 32'hFF
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rbus_pkg::rbus_req_t req_i,
    output rbus_pkg::rbus_req_t req_o,
    output rbus_pkg::locl_req_t locl_req_o,
    input  rbus_pkg::rbus_rsp_t locl_rsp_i,
    input  rbus_pkg::rbus_rsp_t rsp_i,
    output rbus_pkg::rbus_rsp_t rsp_o
);
    import rbus_pkg::*;

    rbus_req_t req_q;
    rbus_rsp_t rsp_q;
    logic      req_vld;
    logic      win_hit;
    logic      locl_vld;

    assign req_vld  = req_q.wr_strb | req_q.rd_strb;
    assign win_hit  = (req_q.addr >= win_start) && (req_q.addr <= win_end);
    assign locl_vld = locl_rsp_i.ack | locl_rsp_i.err_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q      <= '0;
            rsp_q      <= '0;
            req_o      <= '0;
            locl_req_o <= '0;
            rsp_o      <= '0;
        end else begin
            req_q <= req_i;  // input stage.
            rsp_q <= rsp_i;

            // strobes are single-cycle, payload holds.
            req_o.wr_strb      <= 1'b0;
            req_o.rd_strb      <= 1'b0;
            locl_req_o.wr_strb <= 1'b0;
            locl_req_o.rd_strb <= 1'b0;

            if (req_vld) begin
                if (win_hit) begin
                    locl_req_o.addr    <= req_q.addr[locl_addr_w-1:0];  // offset only.
                    locl_req_o.wr_strb <= req_q.wr_strb;
                    locl_req_o.wr_data <= req_q.wr_data;
                    locl_req_o.rd_strb <= req_q.rd_strb;
                end else begin
                    req_o <= req_q;  // not ours, pass on.
                end
            end

            // local answer wins over upstream traffic.
            if (locl_vld) begin
                rsp_o <= locl_rsp_i;
            end else begin
                rsp_o <= rsp_q;
            end
        end
    end

endmodule

/* logic/rbus_reg_block.sv */
`timescale 1ns/100ps

module rbus_reg_block #(
    parameter int unsigned node_id = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rbus_pkg::locl_req_t locl_req_i,
    output rbus_pkg::rbus_rsp_t locl_rsp_o
);
    import rbus_pkg::*;

    logic [data_w-1:0] regs [0:2];
    logic [1:0]        reg_idx;
    logic              rw_hit;
    logic              id_hit;
    logic              req_vld;

    assign req_vld = locl_req_i.wr_strb | locl_req_i.rd_strb;
    assign reg_idx = locl_req_i.addr[3:2];
    assign rw_hit  = (locl_req_i.addr == 8'h00) ||
                     (locl_req_i.addr == 8'h04) ||
                     (locl_req_i.addr == 8'h08);
    assign id_hit  = (locl_req_i.addr == 8'h0C);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs[0]    <= '0;
            regs[1]    <= '0;
            regs[2]    <= '0;
            locl_rsp_o <= '0;
        end else begin
            locl_rsp_o <= '0;  // idle beat.
            if (req_vld) begin
                if (rw_hit) begin
                    locl_rsp_o.ack <= 1'b1;
                    if (locl_req_i.wr_strb) begin
                        regs[reg_idx] <= locl_req_i.wr_data;
                    end else begin
                        locl_rsp_o.rd_data <= regs[reg_idx];
                    end
                end else if (id_hit && locl_req_i.rd_strb) begin
                    locl_rsp_o.ack     <= 1'b1;
                    locl_rsp_o.rd_data <= data_w'(node_id);
                end else begin
                    // id write or unmapped offset.
                    locl_rsp_o.err_ack <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/rbus_ring_master.sv */
`timescale 1ns/100ps

module rbus_ring_master (
    input  logic                clk,
    input  logic                rst_n,
    input  rbus_pkg::rbus_req_t host_req_i,
    output logic                host_ready_o,
    output logic                host_done_o,
    output rbus_pkg::host_rsp_t host_rsp_o,
    output rbus_pkg::rbus_req_t ring_req_o,
    input  rbus_pkg::rbus_rsp_t ring_rsp_i,
    input  rbus_pkg::rbus_req_t ret_req_i
);
    import rbus_pkg::*;

    master_state_e state_q;
    host_rsp_t     rsp_q;
    logic          host_strb;
    logic          ret_strb;

    assign host_strb = host_req_i.wr_strb | host_req_i.rd_strb;
    assign ret_strb  = ret_req_i.wr_strb | ret_req_i.rd_strb;  // came back unclaimed.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= idle;
            ring_req_o <= '0;
            rsp_q      <= '0;
        end else begin
            ring_req_o.wr_strb <= 1'b0;
            ring_req_o.rd_strb <= 1'b0;
            case (state_q)
                idle: begin
                    if (host_strb) begin
                        ring_req_o <= host_req_i;  // one-cycle launch.
                        state_q    <= wait_rsp;
                    end
                end
                wait_rsp: begin
                    if (ring_rsp_i.ack) begin
                        rsp_q.rd_data <= ring_rsp_i.rd_data;
                        rsp_q.err     <= 1'b0;
                        state_q       <= done;
                    end else if (ring_rsp_i.err_ack) begin
                        rsp_q.rd_data <= ring_rsp_i.rd_data;
                        rsp_q.err     <= 1'b1;
                        state_q       <= done;
                    end else if (ret_strb) begin
                        rsp_q.rd_data <= '0;  // no node owns it.
                        rsp_q.err     <= 1'b1;
                        state_q       <= done;
                    end
                end
                done: begin
                    state_q <= idle;
                end
                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

    assign host_ready_o = (state_q == idle);
    assign host_done_o  = (state_q == done);
    assign host_rsp_o   = rsp_q;

endmodule

/* logic/rbus_ring_top.sv */
`timescale 1ns/100ps

module rbus_ring_top (
    input  logic                clk,
    input  logic                rst_n,
    input  rbus_pkg::rbus_req_t host_req_i,
    output logic                host_ready_o,
    output logic                host_done_o,
    output rbus_pkg::host_rsp_t host_rsp_o
);
    import rbus_pkg::*;

    // chain index k feeds node k, index n_nodes returns to the master.
    rbus_req_t req_chain [0:n_nodes];
    rbus_rsp_t rsp_chain [0:n_nodes];
    locl_req_t locl_req  [0:n_nodes-1];
    rbus_rsp_t locl_rsp  [0:n_nodes-1];

    assign rsp_chain[0] = '0;  // head of response chain.

    rbus_ring_master u_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_req_i   (host_req_i),
        .host_ready_o (host_ready_o),
        .host_done_o  (host_done_o),
        .host_rsp_o   (host_rsp_o),
        .ring_req_o   (req_chain[0]),
        .ring_rsp_i   (rsp_chain[n_nodes]),
        .ret_req_i    (req_chain[n_nodes])
    );

    for (genvar k = 0; k < n_nodes; k++) begin : g_node
        localparam logic [ring_addr_w-1:0] start_addr = win_base + k * win_size;
        localparam logic [ring_addr_w-1:0] end_addr   = start_addr + win_size - 1;

        rbus_ring_node #(
            .win_start (start_addr),
            .win_end   (end_addr)
        ) u_node (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_i      (req_chain[k]),
            .req_o      (req_chain[k+1]),
            .locl_req_o (locl_req[k]),
            .locl_rsp_i (locl_rsp[k]),
            .rsp_i      (rsp_chain[k]),
            .rsp_o      (rsp_chain[k+1])
        );

        rbus_reg_block #(
            .node_id (k)
        ) u_regs (
            .clk        (clk),
            .rst_n      (rst_n),
            .locl_req_i (locl_req[k]),
            .locl_rsp_o (locl_rsp[k])
        );
    end

endmodule

/* verification/rbus_ring_sva.sv */
`timescale 1ns/100ps

module rbus_ring_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                host_ready_o,
    input logic                host_done_o,
    input rbus_pkg::rbus_req_t ring_req_o,
    input rbus_pkg::rbus_rsp_t ring_rsp_i
);

    logic launch;

    assign launch = ring_req_o.wr_strb | ring_req_o.rd_strb;

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        host_done_o |=> !host_done_o)
        else $error("host_done_o stayed high for more than one cycle");

    launch_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
        launch |-> $past(host_ready_o))  // launch only follows an idle cycle.
        else $error("ring strobe launched while the master was not idle");

    rsp_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ring_rsp_i.ack && ring_rsp_i.err_ack))
        else $error("ack and err_ack high in the same cycle");

endmodule

bind rbus_ring_master rbus_ring_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .host_ready_o (host_ready_o),
    .host_done_o  (host_done_o),
    .ring_req_o   (ring_req_o),
    .ring_rsp_i   (ring_rsp_i)
);

/* verification/rbus_ring_tb.sv */
`timescale 1ns/100ps

module rbus_ring_tb;
    import rbus_pkg::*;

    logic      clk;
    logic      rst_n;
    rbus_req_t host_req;
    logic      host_ready;
    logic      host_done;
    host_rsp_t host_rsp;

    logic [data_w-1:0] model [0:n_nodes-1][0:2];  // expected register contents.
    logic [7:0]        offs  [0:5] = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h44};
    integer            seed;
    int                chk_cnt;
    int                err_cnt;
    int                timeout_cnt;

    rbus_ring_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_req_i   (host_req),
        .host_ready_o (host_ready),
        .host_done_o  (host_done),
        .host_rsp_o   (host_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [31:0] node_addr(input int node, input logic [7:0] off);
        return win_base + 32'(node) * win_size + {24'h0, off};
    endfunction

    // node 3 stands for an address outside every window.
    function automatic logic [31:0] random_addr(input logic [31:0] r);
        int         node;
        logic [7:0] off;
        node = int'(r[5:4]);
        off  = offs[int'(r[15:8]) % 6];
        if (node < n_nodes) begin
            return node_addr(node, off);
        end else if (r[16]) begin
            return win_base - win_size + {24'h0, off};  // just below node 0.
        end else begin
            return node_addr(n_nodes, off);  // just past the last window.
        end
    endfunction

    // predicts one command and applies its write to the model.
    task automatic model_access(input logic is_wr, input logic [31:0] addr,
                                input logic [31:0] data, output logic [31:0] exp_data,
                                output logic exp_err);
        logic [31:0] rel;
        int          node;
        logic [7:0]  off;
        exp_data = '0;
        exp_err  = 1'b1;
        rel      = addr - win_base;
        if (addr >= win_base && rel < 32'(n_nodes) * win_size) begin
            node = int'(rel / win_size);
            off  = rel[7:0];
            if (off == 8'h00 || off == 8'h04 || off == 8'h08) begin
                exp_err = 1'b0;
                if (is_wr) begin
                    model[node][off[3:2]] = data;
                end else begin
                    exp_data = model[node][off[3:2]];
                end
            end else if (off == 8'h0C && !is_wr) begin
                exp_err  = 1'b0;
                exp_data = 32'(node);  // id register.
            end
        end
    endtask

    task automatic issue(input logic is_wr, input logic [31:0] addr, input logic [31:0] data,
                         output host_rsp_t rsp, output logic ok);
        int n;
        ok  = 1'b0;
        rsp = '0;
        n   = 0;
        while (!host_ready && n < 50) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!host_ready) begin
            timeout_cnt++;
            $display("timeout: host_ready_o stayed low for 50 cycles before 0x%08h", addr);
        end else begin
            host_req.addr    = addr;
            host_req.wr_data = data;
            host_req.wr_strb = is_wr;
            host_req.rd_strb = !is_wr;
            @(posedge clk);
            #2;
            host_req.wr_strb = 1'b0;
            host_req.rd_strb = 1'b0;
            n = 0;
            while (!host_done && n < 50) begin
                check_value("host_ready_o", 32'(host_ready), 32'h0);  // busy until done.
                @(posedge clk);
                #2;
                n++;
            end
            if (host_done) begin
                rsp = host_rsp;
                ok  = 1'b1;
            end else begin
                timeout_cnt++;
                $display("timeout: host_done_o did not pulse within 50 cycles for 0x%08h", addr);
            end
        end
    endtask

    task automatic do_cmd(input logic is_wr, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] exp_data;
        logic        exp_err;
        host_rsp_t   got;
        logic        ok;
        model_access(is_wr, addr, data, exp_data, exp_err);
        issue(is_wr, addr, data, got, ok);
        if (ok) begin
            check_value($sformatf("host_rsp_o.err @%08h", addr), 32'(got.err), 32'(exp_err));
            if (!is_wr || exp_err) begin  // write data is don't care.
                check_value($sformatf("host_rsp_o.rd_data @%08h", addr), got.rd_data, exp_data);
            end
        end
    endtask

    task automatic read_all();
        for (int k = 0; k < n_nodes; k++) begin
            for (int r = 0; r < 3; r++) begin
                do_cmd(1'b0, node_addr(k, offs[r]), '0);
            end
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        seed        = 92437;
        chk_cnt     = 0;
        err_cnt     = 0;
        timeout_cnt = 0;
        rst_n       = 1'b0;
        host_req    = '0;
        for (int k = 0; k < n_nodes; k++) begin
            for (int r = 0; r < 3; r++) begin
                model[k][r] = '0;
            end
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("host_ready_o", 32'(host_ready), 32'h1);
        check_value("host_done_o", 32'(host_done), 32'h0);
        read_all();

        // write and read back each rw register then look at all of them.
        for (int k = 0; k < n_nodes; k++) begin
            for (int r = 0; r < 3; r++) begin
                addr = node_addr(k, offs[r]);
                rnd  = $random(seed);
                do_cmd(1'b1, addr, rnd);
                do_cmd(1'b0, addr, '0);
            end
        end
        read_all();

        // id register and unmapped offsets.
        for (int k = 0; k < n_nodes; k++) begin
            rnd = $random(seed);
            do_cmd(1'b0, node_addr(k, 8'h0C), '0);
            do_cmd(1'b1, node_addr(k, 8'h0C), rnd);
            do_cmd(1'b0, node_addr(k, 8'h0C), '0);
            do_cmd(1'b0, node_addr(k, 8'h10), '0);
            do_cmd(1'b1, node_addr(k, 8'h44), 32'hA5A5_5A5A);
            do_cmd(1'b0, node_addr(k, 8'h44), '0);
        end

        // nobody claims these.
        do_cmd(1'b0, win_base - 32'h4, '0);
        do_cmd(1'b1, win_base - win_size, 32'h1234_5678);
        do_cmd(1'b0, node_addr(n_nodes, 8'h04), '0);
        do_cmd(1'b1, 32'hFFFF_FFF0, 32'h0BAD_F00D);

        for (int i = 0; i < 400; i++) begin
            rnd = $random(seed);
            do_cmd(rnd[0], random_addr(rnd), $random(seed));
        end
        read_all();

        $display("checks: %0d  mismatches: %0d  timeouts: %0d", chk_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* rbus_ring.f */
logic/rbus_pkg.sv
logic/rbus_ring_node.sv
logic/rbus_reg_block.sv
logic/rbus_ring_master.sv
logic/rbus_ring_top.sv
verification/rbus_ring_sva.sv
verification/rbus_ring_tb.sv

/* Makefile */
TOP := rbus_ring_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -f rbus_ring.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
